// ==== include/itlb_macros.svh ====
`ifndef ITLB_MACROS_SVH
`define ITLB_MACROS_SVH

// Number of fully associative entries
`define ITLB_ENTRIES 8

// Address space identifier width, as in satp
`define ASID_LEN 16

// Significant virtual bits for Sv39
`define VADDR_LEN 39

// Physical address width
`define PADDR_LEN 56

// Register width of the core
`define XLEN 64

`endif

// ==== itlb_subsys.f ====
+incdir+include
logic/itlb_pkg.sv
logic/hs_slot.sv
logic/itlb_nru.sv
logic/itlb_ctrl.sv
logic/itlb_l1.sv
logic/itlb_subsys.sv
tb/itlb_props.sv
tb/tb_itlb_subsys.sv

// ==== logic/hs_slot.sv ====
`timescale 1ns/1ns

module hs_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  payload_t payload_i,
  input  logic     done_i,
  output logic     valid_o,
  output payload_t payload_o
);

  logic     valid_q;
  logic     done_q;
  logic     capture;
  payload_t payload_q;

  // Armed only while empty, so a held req is never taken twice
  assign capture = req_i && !valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
      done_q  <= 1'b0;
    end else if (valid_q && (done_i || done_q) && !req_i) begin
      // Completed and req has fallen, rearm
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else if (valid_q && done_i) begin
      // Remember completion until the requester lets go
      done_q <= 1'b1;
    end
  end

  // Payload register, loaded once per transfer
  always_ff @(posedge clk_i) begin
    if (capture) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

endmodule

// ==== logic/itlb_ctrl.sv ====
`timescale 1ns/1ns

module itlb_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   vmem_on_i,
  input  logic                   req_valid_i,
  input  logic                   hit_i,
  input  logic                   canon_fault_i,
  input  logic                   l2_ack_i,
  input  itlb_pkg::exception_e   l2_exc_i,
  input  itlb_pkg::tlb_flush_e   flush_i,
  output logic                   req_done_o,
  output logic                   fetch_ack_o,
  output logic                   l2_req_o,
  output logic                   refill_o,
  output logic                   fault_sel_o,
  output logic                   flush_en_o
);

  import itlb_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    L2Wait,
    L2Release,
    Answer,
    AnswerRelease
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   l2_req_q;
  logic   fault_sel_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // First lookup happens on the cycle after the slot captured
      Idle: begin
        if (req_valid_i) begin
          if (!vmem_on_i || canon_fault_i || hit_i) begin
            state_d = Answer;
          end else begin
            state_d = L2Wait;
          end
        end
      end
      // Repeat lookup once the refilled entry is in place
      Lookup: begin
        if (hit_i) begin
          state_d = Answer;
        end else begin
          state_d = L2Wait;
        end
      end
      L2Wait: begin
        if (l2_ack_i) begin
          state_d = L2Release;
        end
      end
      // Refill cycle first, then wait for the L2 to drop ack
      L2Release: begin
        if (!l2_req_q && !l2_ack_i) begin
          if (l2_exc_i == PageFault) begin
            state_d = Answer;
          end else begin
            state_d = Lookup;
          end
        end
      end
      Answer: begin
        state_d = AnswerRelease;
      end
      // Hold ack until the request slot sees req fall
      AnswerRelease: begin
        if (!req_valid_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      l2_req_q    <= 1'b0;
      fault_sel_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // Req stays up through the refill cycle after ack
      l2_req_q <= (state_d == L2Wait) || (state_q == L2Wait);
      if (state_d == Idle) begin
        fault_sel_q <= 1'b0;
      end else if (state_q == L2Release && state_d == Answer) begin
        fault_sel_q <= 1'b1;
      end
    end
  end

  assign l2_req_o    = l2_req_q;
  assign refill_o    = (state_q == L2Release) && l2_req_q;
  assign req_done_o  = (state_q == Answer);
  assign fetch_ack_o = (state_q == Answer) || (state_q == AnswerRelease);
  assign fault_sel_o = fault_sel_q;

  // Flush only with nothing in flight
  assign flush_en_o  = (state_q == Idle) && !req_valid_i && (flush_i != NoFlush);

endmodule

// ==== logic/itlb_l1.sv ====
`timescale 1ns/1ns
`include "itlb_macros.svh"

module itlb_l1 (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     vmem_on_i,
  input  itlb_pkg::priv_e          priv_i,
  input  itlb_pkg::asid_t          asid_i,
  input  itlb_pkg::vaddr_t         vaddr_i,
  input  logic                     refill_i,
  input  logic [`ITLB_ENTRIES-1:0] victim_vec_i,
  input  itlb_pkg::l2_ans_t        ans_i,
  input  logic                     flush_en_i,
  input  itlb_pkg::tlb_flush_e     flush_type_i,
  input  itlb_pkg::asid_t          flush_asid_i,
  input  itlb_pkg::vpn_t           flush_vpn_i,
  input  logic                     fault_sel_i,
  output logic                     hit_o,
  output logic [`ITLB_ENTRIES-1:0] hit_vec_o,
  output logic [`ITLB_ENTRIES-1:0] valid_vec_o,
  output logic                     canon_fault_o,
  output itlb_pkg::paddr_t         paddr_o,
  output itlb_pkg::exception_e     exc_o
);

  import itlb_pkg::*;

  localparam int N    = `ITLB_ENTRIES;
  localparam int IdxW = $clog2(N);

  // Entry storage, only the valid bits are control state
  logic [N-1:0] valid_q;
  vpn_t         vpn_q  [N];
  ppn_t         ppn_q  [N];
  asid_t        asid_q [N];
  page_type_e   type_q [N];
  logic [N-1:0] glob_q;
  logic [N-1:0] user_q;

  exception_e      l2_exc_q;
  logic            refill_write;
  logic [N-1:0]    flush_vec;
  logic [N-1:0]    hit_raw;
  logic [IdxW-1:0] hit_idx;
  logic            perm_fault;

  // VPN compare at the granularity of the entry page size
  function automatic logic vpn_match(vpn_t entry_vpn, page_type_e pt, vpn_t vpn);
    logic m;
    m = (entry_vpn[2] == vpn[2]);
    if (pt != GibiPage) begin
      m = m && (entry_vpn[1] == vpn[1]);
    end
    if (pt == KibiPage) begin
      m = m && (entry_vpn[0] == vpn[0]);
    end
    return m;
  endfunction

  // Faulting L2 answers are never cached
  assign refill_write = refill_i && (ans_i.exc == NoException);

  // Flush mask, global entries survive the ASID kinds
  always_comb begin
    logic asid_hit;
    logic page_hit;
    flush_vec = '0;
    for (int k = 0; k < N; k++) begin
      asid_hit = (asid_q[k] == flush_asid_i) && !glob_q[k];
      page_hit = vpn_match(vpn_q[k], type_q[k], flush_vpn_i);
      unique case (flush_type_i)
        FlushAll:      flush_vec[k] = 1'b1;
        FlushAsid:     flush_vec[k] = asid_hit;
        FlushPage:     flush_vec[k] = page_hit;
        FlushAsidPage: flush_vec[k] = asid_hit && page_hit;
        default:       flush_vec[k] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_en_i) begin
      valid_q <= valid_q & ~flush_vec;
    end else if (refill_write) begin
      valid_q <= valid_q | victim_vec_i;
    end
  end

  // Tag and data of the victim, tagged with the current ASID
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < N; k++) begin
      if (refill_write && victim_vec_i[k]) begin
        vpn_q[k]  <= vaddr_i.vpn;
        ppn_q[k]  <= ans_i.ppn;
        asid_q[k] <= asid_i;
        type_q[k] <= ans_i.page_type;
        glob_q[k] <= ans_i.glob;
        user_q[k] <= ans_i.user;
      end
    end
  end

  // L2 status kept for a fault answer after ack has dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      l2_exc_q <= NoException;
    end else if (refill_i) begin
      l2_exc_q <= ans_i.exc;
    end
  end

  // Associative compare, ASID or global bit must match
  always_comb begin
    hit_raw = '0;
    hit_idx = '0;
    for (int k = 0; k < N; k++) begin
      if (valid_q[k] && ((asid_q[k] == asid_i) || glob_q[k]) &&
          vpn_match(vpn_q[k], type_q[k], vaddr_i.vpn)) begin
        hit_raw[k] = 1'b1;
        hit_idx    = IdxW'(k);
      end
    end
  end

  // No translation hits with vmem off
  assign hit_vec_o   = hit_raw & {N{vmem_on_i}};
  assign hit_o       = |hit_vec_o;
  assign valid_vec_o = valid_q;

  // Bits 63..39 must all copy bit 38
  assign canon_fault_o = vmem_on_i &&
      (vaddr_i.msb != {(`XLEN-`VADDR_LEN){vaddr_i.vpn[2][8]}});

  // User page from S mode or supervisor page from U mode, SUM ignored for fetch
  assign perm_fault = (user_q[hit_idx] && (priv_i == PrivS)) ||
                      (!user_q[hit_idx] && (priv_i == PrivU));

  always_comb begin
    if (fault_sel_i) begin
      exc_o = l2_exc_q;
    end else if (!vmem_on_i) begin
      exc_o = NoException;
    end else if (canon_fault_o || (hit_o && perm_fault)) begin
      exc_o = PageFault;
    end else begin
      exc_o = NoException;
    end
  end

  // Superpages take the low VPN fields straight from the virtual address
  always_comb begin
    if (!vmem_on_i) begin
      paddr_o = vaddr_i[`PADDR_LEN-1:0];
    end else begin
      unique case (type_q[hit_idx])
        GibiPage: paddr_o = {ppn_q[hit_idx].p2, vaddr_i.vpn[1], vaddr_i.vpn[0], vaddr_i.offset};
        MebiPage: paddr_o = {ppn_q[hit_idx].p2, ppn_q[hit_idx].p1, vaddr_i.vpn[0],
                             vaddr_i.offset};
        default:  paddr_o = {ppn_q[hit_idx], vaddr_i.offset};
      endcase
    end
  end

endmodule

// ==== logic/itlb_nru.sv ====
`timescale 1ns/1ns
`include "itlb_macros.svh"

module itlb_nru (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`ITLB_ENTRIES-1:0] valid_vec_i,
  input  logic                     access_i,
  input  logic [`ITLB_ENTRIES-1:0] hit_vec_i,
  output logic [`ITLB_ENTRIES-1:0] victim_vec_o
);

  localparam int N = `ITLB_ENTRIES;

  logic [N-1:0] used_q;
  logic [N-1:0] used_set;

  // Invalid entries lose their used bit, the hit entry gains it
  assign used_set = (used_q & valid_vec_i) | hit_vec_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else if (access_i && |hit_vec_i) begin
      // All used: start a new epoch keeping only the last access
      if (&used_set) begin
        used_q <= hit_vec_i;
      end else begin
        used_q <= used_set;
      end
    end
  end

  // First invalid entry wins, then first entry not recently used
  always_comb begin
    logic found;
    victim_vec_o = '0;
    found        = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (!found && !valid_vec_i[k]) begin
        victim_vec_o[k] = 1'b1;
        found           = 1'b1;
      end
    end
    for (int k = 0; k < N; k++) begin
      if (!found && !used_q[k]) begin
        victim_vec_o[k] = 1'b1;
        found           = 1'b1;
      end
    end
    // Only reachable if every bit is set, keep a legal one-hot
    if (!found) begin
      victim_vec_o[0] = 1'b1;
    end
  end

endmodule

// ==== logic/itlb_pkg.sv ====
`include "itlb_macros.svh"

package itlb_pkg;

  // Privilege mode of the hart
  typedef enum logic [1:0] {
    PrivU = 2'b00,
    PrivS = 2'b01,
    PrivM = 2'b11
  } priv_e;

  // Kind of sfence.vma flush
  typedef enum logic [2:0] {
    NoFlush       = 3'd0,
    FlushAll      = 3'd1,
    FlushAsid     = 3'd2,
    FlushPage     = 3'd3,
    FlushAsidPage = 3'd4
  } tlb_flush_e;

  // Status returned with a translation
  typedef enum logic {
    NoException = 1'b0,
    PageFault   = 1'b1
  } exception_e;

  // Size of the page that an entry maps
  typedef enum logic [1:0] {
    KibiPage = 2'd0,
    MebiPage = 2'd1,
    GibiPage = 2'd2
  } page_type_e;

  // Three 9-bit VPN fields, index 2 is the top level
  typedef logic [2:0][8:0] vpn_t;

  // Physical page number split at the superpage boundaries
  typedef struct packed {
    logic [25:0] p2;
    logic [8:0]  p1;
    logic [8:0]  p0;
  } ppn_t;

  typedef logic [`ASID_LEN-1:0]  asid_t;
  typedef logic [`PADDR_LEN-1:0] paddr_t;

  // Full 64-bit virtual address, msb must sign-extend bit 38
  typedef struct packed {
    logic [`XLEN-`VADDR_LEN-1:0] msb;
    vpn_t                        vpn;
    logic [11:0]                 offset;
  } vaddr_t;

  // Answer from the L2 translation source
  typedef struct packed {
    ppn_t       ppn;
    page_type_e page_type;
    logic       user;
    logic       glob;
    exception_e exc;
  } l2_ans_t;

endpackage

// ==== logic/itlb_subsys.sv ====
`timescale 1ns/1ns
`include "itlb_macros.svh"

module itlb_subsys (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Fetch channel
  input  logic                   fetch_req_i,
  input  itlb_pkg::vaddr_t       fetch_vaddr_i,
  output logic                   fetch_ack_o,
  output itlb_pkg::paddr_t       fetch_paddr_o,
  output itlb_pkg::exception_e   fetch_exc_o,
  // L2 channel
  output logic                   l2_req_o,
  output itlb_pkg::vpn_t         l2_vpn_o,
  input  logic                   l2_ack_i,
  input  itlb_pkg::ppn_t         l2_ppn_i,
  input  itlb_pkg::page_type_e   l2_page_type_i,
  input  logic                   l2_user_i,
  input  logic                   l2_glob_i,
  input  itlb_pkg::exception_e   l2_exc_i,
  // Configuration from CSRs and sfence.vma
  input  logic                   vmem_on_i,
  input  itlb_pkg::priv_e        priv_i,
  input  itlb_pkg::asid_t        asid_i,
  input  itlb_pkg::tlb_flush_e   flush_i,
  input  itlb_pkg::asid_t        flush_asid_i,
  input  itlb_pkg::vpn_t         flush_vpn_i
);

  import itlb_pkg::*;

  vaddr_t  req_vaddr;
  logic    req_valid;
  logic    req_done;
  l2_ans_t l2_ans;
  l2_ans_t refill_ans;
  logic    hit;
  logic    canon_fault;
  logic    refill;
  logic    fault_sel;
  logic    flush_en;

  logic [`ITLB_ENTRIES-1:0] hit_vec;
  logic [`ITLB_ENTRIES-1:0] valid_vec;
  logic [`ITLB_ENTRIES-1:0] victim_vec;

  // Loose L2 answer fields packed for the refill slot
  assign l2_ans = '{ppn: l2_ppn_i, page_type: l2_page_type_i, user: l2_user_i,
                    glob: l2_glob_i, exc: l2_exc_i};

  // Miss refill asks for the VPN of the held request
  assign l2_vpn_o = req_vaddr.vpn;

  hs_slot #(
    .payload_t(vaddr_t)
  ) u_req_slot (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (fetch_req_i),
    .payload_i(fetch_vaddr_i),
    .done_i   (req_done),
    .valid_o  (req_valid),
    .payload_o(req_vaddr)
  );

  itlb_ctrl u_itlb_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .vmem_on_i    (vmem_on_i),
    .req_valid_i  (req_valid),
    .hit_i        (hit),
    .canon_fault_i(canon_fault),
    .l2_ack_i     (l2_ack_i),
    .l2_exc_i     (refill_ans.exc),
    .flush_i      (flush_i),
    .req_done_o   (req_done),
    .fetch_ack_o  (fetch_ack_o),
    .l2_req_o     (l2_req_o),
    .refill_o     (refill),
    .fault_sel_o  (fault_sel),
    .flush_en_o   (flush_en)
  );

  itlb_l1 u_itlb_l1 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .vmem_on_i    (vmem_on_i),
    .priv_i       (priv_i),
    .asid_i       (asid_i),
    .vaddr_i      (req_vaddr),
    .refill_i     (refill),
    .victim_vec_i (victim_vec),
    .ans_i        (refill_ans),
    .flush_en_i   (flush_en),
    .flush_type_i (flush_i),
    .flush_asid_i (flush_asid_i),
    .flush_vpn_i  (flush_vpn_i),
    .fault_sel_i  (fault_sel),
    .hit_o        (hit),
    .hit_vec_o    (hit_vec),
    .valid_vec_o  (valid_vec),
    .canon_fault_o(canon_fault),
    .paddr_o      (fetch_paddr_o),
    .exc_o        (fetch_exc_o)
  );

  // Used bits follow the answered hits
  itlb_nru u_itlb_nru (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_vec_i (valid_vec),
    .access_i    (req_done),
    .hit_vec_i   (hit_vec),
    .victim_vec_o(victim_vec)
  );

  // The control unit tracks the ack phases, so the slot's valid flag is left open
  hs_slot #(
    .payload_t(l2_ans_t)
  ) u_refill_slot (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (l2_ack_i),
    .payload_i(l2_ans),
    .done_i   (refill),
    .valid_o  (),
    .payload_o(refill_ans)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ITLB testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_itlb_subsys -f itlb_subsys.f \
  -Mdir obj_dir -o tb_itlb_subsys > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_itlb_subsys > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

// ==== tb/itlb_props.sv ====
`timescale 1ns/1ns

module itlb_props (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 fetch_req_i,
  input logic                 fetch_ack_o,
  input logic                 l2_req_o,
  input logic                 l2_ack_i,
  input logic                 req_valid_i,
  input itlb_pkg::tlb_flush_e flush_i
);

  import itlb_pkg::*;

  // Both channels quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !fetch_ack_o && !l2_req_o)
    else $error("fetch_ack_o or l2_req_o high in reset");

  // L2 request is held until the L2 acknowledges
  l2_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      l2_req_o && !l2_ack_i |=> l2_req_o)
    else $error("l2_req_o dropped before l2_ack_i");

  // No ack out of an idle fetch channel
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !fetch_req_i && !fetch_ack_o |=> !fetch_ack_o)
    else $error("fetch_ack_o rose without a request");

  flush_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (flush_i != NoFlush) |-> !fetch_req_i && !fetch_ack_o && !l2_req_o && !req_valid_i)
    else $error("flush_i seen with a translation in flight");

endmodule

bind itlb_subsys itlb_props u_itlb_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .fetch_req_i(fetch_req_i),
  .fetch_ack_o(fetch_ack_o),
  .l2_req_o   (l2_req_o),
  .l2_ack_i   (l2_ack_i),
  .req_valid_i(req_valid),
  .flush_i    (flush_i)
);

// ==== tb/tb_itlb_subsys.sv ====
`timescale 1ns/1ns
`include "itlb_macros.svh"

module tb_itlb_subsys;

  import itlb_pkg::*;

  localparam int WaitLimit = 200;
  localparam int Sweep     = 2 * `ITLB_ENTRIES + 4;
  // Fixed XOR that the L2 model applies to the VPN
  localparam logic [43:0] PpnXor = 44'h9e3_7796_b4c1;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       fetch_req;
  vaddr_t     fetch_vaddr;
  logic       fetch_ack;
  paddr_t     fetch_paddr;
  exception_e fetch_exc;
  logic       l2_req;
  vpn_t       l2_vpn;
  logic       l2_ack;
  ppn_t       l2_ppn;
  page_type_e l2_page_type;
  logic       l2_user;
  logic       l2_glob;
  exception_e l2_exc;
  logic       vmem_on;
  priv_e      priv;
  asid_t      asid;
  tlb_flush_e flush;
  asid_t      flush_asid;
  vpn_t       flush_vpn;

  int l2_count  = 0;
  int checks    = 0;
  int errors    = 0;
  int tests     = 0;
  int failed    = 0;
  int test_base = 0;
  int last_lat  = 0;
  int page_seq  = 0;

  itlb_subsys u_itlb_subsys (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_vaddr_i (fetch_vaddr),
    .fetch_ack_o   (fetch_ack),
    .fetch_paddr_o (fetch_paddr),
    .fetch_exc_o   (fetch_exc),
    .l2_req_o      (l2_req),
    .l2_vpn_o      (l2_vpn),
    .l2_ack_i      (l2_ack),
    .l2_ppn_i      (l2_ppn),
    .l2_page_type_i(l2_page_type),
    .l2_user_i     (l2_user),
    .l2_glob_i     (l2_glob),
    .l2_exc_i      (l2_exc),
    .vmem_on_i     (vmem_on),
    .priv_i        (priv),
    .asid_i        (asid),
    .flush_i       (flush),
    .flush_asid_i  (flush_asid),
    .flush_vpn_i   (flush_vpn)
  );

  always #2 clk = ~clk;

  // Answer rule of the L2 translation source
  function automatic l2_ans_t l2_rule(vpn_t vpn);
    l2_ans_t a;
    case (vpn[2][1:0])
      2'd1:    a.page_type = MebiPage;
      2'd2:    a.page_type = GibiPage;
      default: a.page_type = KibiPage;
    endcase
    a.user = vpn[0][0];
    a.glob = vpn[1][3];
    a.ppn  = ppn_t'({17'd0, vpn} ^ PpnXor);
    a.exc  = (vpn[2] == 9'h1ff) ? PageFault : NoException;
    return a;
  endfunction

  // Expected physical address where superpages keep the low VPN fields
  function automatic paddr_t model_paddr(vaddr_t va);
    l2_ans_t a;
    a = l2_rule(va.vpn);
    if (!vmem_on) begin
      return va[`PADDR_LEN-1:0];
    end
    case (a.page_type)
      GibiPage: return {a.ppn.p2, va.vpn[1], va.vpn[0], va.offset};
      MebiPage: return {a.ppn.p2, a.ppn.p1, va.vpn[0], va.offset};
      default:  return {a.ppn, va.offset};
    endcase
  endfunction

  function automatic exception_e model_exc(vaddr_t va);
    l2_ans_t a;
    logic    canonical;
    a = l2_rule(va.vpn);
    // Bits 63..38 all equal
    canonical = (va[`XLEN-1:`VADDR_LEN-1] == '0) || (va[`XLEN-1:`VADDR_LEN-1] == '1);
    if (!vmem_on) begin
      return NoException;
    end
    if (!canonical || a.exc == PageFault) begin
      return PageFault;
    end
    if ((a.user && priv == PrivS) || (!a.user && priv == PrivU)) begin
      return PageFault;
    end
    return NoException;
  endfunction

  // Fresh canonical page whose top VPN field does not repeat within 128 pages
  function automatic vaddr_t new_page(logic glob);
    vaddr_t va;
    page_seq++;
    va.vpn[2]    = {page_seq[6:0], 2'(page_seq % 3)};
    va.vpn[1]    = 9'($urandom);
    va.vpn[1][3] = glob;
    va.vpn[0]    = 9'($urandom);
    va.offset    = 12'($urandom);
    va.msb       = {(`XLEN-`VADDR_LEN){va.vpn[2][8]}};
    return va;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Counts falling edges until fetch ack reaches the level
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (fetch_ack !== level && cycles < WaitLimit);
    if (fetch_ack !== level) begin
      abort_run("fetch_ack_o did not reach the expected level");
    end
  endtask

  // One full four-phase fetch that returns the answer and the L2 requests it caused
  task automatic fetch(input vaddr_t va, output paddr_t pa, output exception_e exc,
                       output int reqs);
    int start;
    int release_cycles;
    start       = l2_count;
    fetch_vaddr = va;
    fetch_req   = 1'b1;
    wait_ack(1'b1, last_lat);
    pa          = fetch_paddr;
    exc         = fetch_exc;
    fetch_req   = 1'b0;
    wait_ack(1'b0, release_cycles);
    reqs = l2_count - start;
  endtask

  // Negative exp_l2 skips the request count
  task automatic access(input vaddr_t va, input int exp_l2);
    paddr_t     pa;
    exception_e exc;
    exception_e exp_exc;
    int         reqs;
    exp_exc = model_exc(va);
    fetch(va, pa, exc, reqs);
    check_equal("fetch_exc_o", 64'(exc), 64'(exp_exc));
    if (exp_exc == NoException) begin
      check_equal("fetch_paddr_o", 64'(pa), 64'(model_paddr(va)));
    end
    if (exp_l2 >= 0) begin
      check_equal("l2_req_o count", 64'(reqs), 64'(exp_l2));
    end
  endtask

  // Access with the privilege that the page allows
  task automatic touch(input vaddr_t va, input int exp_l2);
    l2_ans_t a;
    a    = l2_rule(va.vpn);
    priv = a.user ? PrivU : PrivS;
    access(va, exp_l2);
  endtask

  // Flush is held for exactly one sampling edge
  task automatic flush_tlb(input tlb_flush_e kind, input asid_t fasid, input vpn_t fvpn);
    flush      = kind;
    flush_asid = fasid;
    flush_vpn  = fvpn;
    @(negedge clk);
    flush = NoFlush;
  endtask

  task automatic close_test(input string name);
    tests++;
    if (errors == test_base) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // L2 side answers from the VPN and releases after req drops
  initial begin : l2_responder
    l2_ans_t ans;
    l2_ack       = 1'b0;
    l2_ppn       = '0;
    l2_page_type = KibiPage;
    l2_user      = 1'b0;
    l2_glob      = 1'b0;
    l2_exc       = NoException;
    forever begin
      @(negedge clk);
      if (l2_req && !l2_ack) begin
        // The requested VPN belongs to the fetch that is pending
        check_equal("l2_vpn_o", 64'(l2_vpn), 64'(fetch_vaddr.vpn));
        ans          = l2_rule(l2_vpn);
        l2_ppn       = ans.ppn;
        l2_page_type = ans.page_type;
        l2_user      = ans.user;
        l2_glob      = ans.glob;
        l2_exc       = ans.exc;
        l2_ack       = 1'b1;
        l2_count++;
      end else if (!l2_req && l2_ack) begin
        l2_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    vaddr_t     va;
    vaddr_t     pa_a;
    vaddr_t     pa_b;
    vaddr_t     pa_g;
    vaddr_t     sweep [Sweep];
    tlb_flush_e kinds [4];
    void'($urandom(32'h97ac));
    page_seq    = int'($urandom % 128);
    kinds       = '{FlushAll, FlushAsid, FlushPage, FlushAsidPage};
    rst_n       = 1'b0;
    fetch_req   = 1'b0;
    fetch_vaddr = '0;
    vmem_on     = 1'b0;
    priv        = PrivS;
    asid        = '0;
    flush       = NoFlush;
    flush_asid  = '0;
    flush_vpn   = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Any address passes through in two edges with vmem off
    for (int i = 0; i < 10; i++) begin
      va = vaddr_t'({$urandom, $urandom});
      access(va, 0);
      check_equal("fetch_ack_o latency", 64'(last_lat), 64'd2);
    end
    close_test("bare mode");

    // Miss then hit across all three page sizes
    vmem_on = 1'b1;
    asid    = 16'h1;
    flush_tlb(FlushAll, '0, '0);
    for (int i = 0; i < 12; i++) begin
      va = new_page(1'($urandom));
      touch(va, 1);
      va.offset = 12'($urandom);
      touch(va, 0);
    end
    close_test("page sizes");

    // Non-canonical address and an L2 fault seen twice, then wrong privilege on a cached page
    va     = new_page(1'b0);
    va.msb = ~va.msb;
    touch(va, 0);
    va        = new_page(1'b0);
    va.vpn[2] = 9'h1ff;
    va.msb    = '1;
    touch(va, 1);
    touch(va, 1);
    for (int u = 0; u < 2; u++) begin
      va          = new_page(1'b0);
      va.vpn[0][0] = u[0];
      touch(va, 1);
      priv = (priv == PrivU) ? PrivS : PrivU;
      access(va, 0);
    end
    close_test("faults");

    // Private entry misses under another ASID while the global entry hits
    flush_tlb(FlushAll, '0, '0);
    asid = 16'h1;
    pa_a = new_page(1'b0);
    pa_g = new_page(1'b1);
    touch(pa_a, 1);
    touch(pa_g, 1);
    asid = 16'h2;
    touch(pa_a, 1);
    touch(pa_g, 0);
    asid = 16'h1;
    touch(pa_a, 0);
    close_test("asid");

    // Page A is hit by every flush kind and pages B and G only by FlushAll
    for (int k = 0; k < 4; k++) begin
      flush_tlb(FlushAll, '0, '0);
      pa_a = new_page(1'b0);
      pa_b = new_page(1'b0);
      pa_g = new_page(1'b1);
      asid = 16'h1;
      touch(pa_a, 1);
      touch(pa_g, 1);
      asid = 16'h2;
      touch(pa_b, 1);
      flush_tlb(kinds[k], 16'h1, pa_a.vpn);
      asid = 16'h1;
      touch(pa_a, 1);
      touch(pa_g, (kinds[k] == FlushAll) ? 1 : 0);
      asid = 16'h2;
      touch(pa_b, (kinds[k] == FlushAll) ? 1 : 0);
      close_test($sformatf("flush %s", kinds[k].name()));
    end

    // More pages than entries so random revisits check only the answer
    flush_tlb(FlushAll, '0, '0);
    asid = 16'h3;
    for (int i = 0; i < Sweep; i++) begin
      sweep[i] = new_page(1'($urandom));
      touch(sweep[i], 1);
    end
    for (int i = 0; i < 2 * Sweep; i++) begin
      touch(sweep[int'($urandom % Sweep)], -1);
    end
    close_test("replacement");

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
